// ==== build.f ====
+incdir+tests
design/bpm_pkg.sv
design/lane_if.sv
design/result_if.sv
design/event_framer.sv
design/channel_proc.sv
design/packet_builder.sv
design/bpm_frontend_top.sv
tests/tb_bpm_frontend.sv

// ==== design/bpm_frontend_top.sv ====
module bpm_frontend_top #(
	parameter int BL_LOG2 = 3  // log2 of baseline window
) (
	input  logic                  clk,
	input  logic                  RST_EVENT_NO,
	input  logic                  sample_valid,
	input  bpm_pkg::quad_sample_t sample_word,
	input  logic [15:0]           evt_len,
	output logic                  busy,
	output logic                  pkt_valid,
	output logic [31:0]           pkt_word
);

	logic pkt_done;  // packet builder -> framer, releases busy

	lane_if   lanes   [bpm_pkg::NUM_CH] ();
	result_if results [bpm_pkg::NUM_CH] ();

	////////////////////////////////////////////////////////////////////////////
	// framing
	////////////////////////////////////////////////////////////////////////////

	event_framer #(
		.BL_LOG2 (BL_LOG2)
	) i_framer (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.sample_valid (sample_valid),
		.sample_word  (sample_word),
		.evt_len      (evt_len),
		.pkt_done     (pkt_done),
		.busy         (busy),
		.lanes        (lanes)
	);

	////////////////////////////////////////////////////////////////////////////
	// per-channel processing
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < bpm_pkg::NUM_CH; g++) begin : g_chan
		channel_proc #(
			.BL_LOG2 (BL_LOG2)
		) i_chan (
			.clk          (clk),
			.RST_EVENT_NO (RST_EVENT_NO),
			.lane         (lanes[g]),
			.res          (results[g])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// packing
	////////////////////////////////////////////////////////////////////////////

	packet_builder i_packer (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.res          (results),
		.pkt_valid    (pkt_valid),
		.pkt_word     (pkt_word),
		.pkt_done     (pkt_done)
	);

endmodule

// ==== design/bpm_pkg.sv ====
package bpm_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and packet constants
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_CH   = 4;   // electrodes A..D, packet layout assumes four
	localparam int SAMPLE_W = 16;  // adc word
	localparam int ENERGY_W = 32;  // sum of squares, saturating
	localparam int PKT_LEN  = 8;   // words per packet

	localparam logic [31:0] PKT_ID = 32'h4142504d;  // "ABPM"

	localparam logic [SAMPLE_W-1:0] OVF_FULL_SCALE = '1;  // raw full scale

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [SAMPLE_W-1:0] sample_t;

	// channel A sits in the low 16 bits, then B, C, D
	typedef sample_t [NUM_CH-1:0] quad_sample_t;

	typedef logic [ENERGY_W-1:0] energy_t;

	// one packet word, either whole (id, energy) or split (status/count, peaks)
	typedef union packed {
		logic [31:0] full;
		struct packed {
			sample_t hi;
			sample_t lo;
		} half;
	} pkt_word_u;

endpackage

// ==== design/channel_proc.sv ====
module channel_proc #(
	parameter int BL_LOG2 = 3
) (
	input  logic   clk,
	input  logic   RST_EVENT_NO,
	lane_if.chan   lane,
	result_if.chan res
);

	localparam int SUM_W = bpm_pkg::SAMPLE_W + BL_LOG2;  // no wrap over the window
	localparam int SQ_W  = 2 * bpm_pkg::SAMPLE_W;
	localparam int ACC_W = bpm_pkg::ENERGY_W + 1;       // one carry bit

	logic [SUM_W-1:0]  bl_sum;
	logic              wait_first;  // next baseline sample opens an event
	logic              first_bl;
	bpm_pkg::sample_t  baseline;
	bpm_pkg::sample_t  corr;        // baseline removed, clamped
	logic [SQ_W-1:0]   sq;
	logic [ACC_W-1:0]  energy_add;
	bpm_pkg::energy_t  energy_sat;
	bpm_pkg::sample_t  peak_q;
	bpm_pkg::energy_t  energy_q;
	logic              ovf_q;
	logic              done_q;

	assign first_bl = lane.bl_valid & wait_first;

	// average over the window, bl_sum is steady once the signal starts
	assign baseline = bl_sum[SUM_W-1:BL_LOG2];

	////////////////////////////////////////////////////////////////////////////
	// correction and energy datapath
	////////////////////////////////////////////////////////////////////////////

	assign corr = (lane.sample > baseline) ? lane.sample - baseline : '0;  // clamp at 0
	assign sq   = corr * corr;

	assign energy_add = ACC_W'(energy_q) + ACC_W'(sq);
	assign energy_sat = energy_add[ACC_W-1] ? '1 : energy_add[bpm_pkg::ENERGY_W-1:0];

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			wait_first <= 1'b1;
			done_q     <= 1'b0;
		end else begin
			if (lane.last)
				wait_first <= 1'b1;  // rearm for the next event
			else if (lane.bl_valid)
				wait_first <= 1'b0;
			done_q <= lane.last;
		end
	end

	// accumulators restart on the first baseline sample, held after done
	always_ff @(posedge clk) begin
		if (first_bl) begin
			bl_sum   <= SUM_W'(lane.sample);
			peak_q   <= '0;
			energy_q <= '0;
			ovf_q    <= 1'b0;
		end else if (lane.bl_valid) begin
			bl_sum <= bl_sum + SUM_W'(lane.sample);
		end else if (lane.sig_valid) begin
			if (corr > peak_q)
				peak_q <= corr;
			energy_q <= energy_sat;
			if (lane.sample == bpm_pkg::OVF_FULL_SCALE)
				ovf_q <= 1'b1;  // raw value, not corrected
		end
	end

	assign res.peak     = peak_q;
	assign res.energy   = energy_q;
	assign res.overflow = ovf_q;
	assign res.done     = done_q;

endmodule

// ==== design/event_framer.sv ====
module event_framer #(
	parameter int BL_LOG2 = 3
) (
	input  logic                  clk,
	input  logic                  RST_EVENT_NO,
	input  logic                  sample_valid,
	input  bpm_pkg::quad_sample_t sample_word,
	input  logic [15:0]           evt_len,
	input  logic                  pkt_done,     // from packet builder
	output logic                  busy,
	lane_if.framer                lanes [bpm_pkg::NUM_CH]
);

	localparam logic [15:0] BL_LEN = 16'(1) << BL_LOG2;  // baseline window size

	logic                  accept;   // sample taken this edge
	logic [15:0]           smp_cnt;  // index of next sample in event
	logic [15:0]           len_q;    // latched event length
	logic [15:0]           len_eff;  // evt_len after minimum rule
	logic                  in_bl;
	logic                  is_last;
	logic                  bl_q;
	logic                  sig_q;
	logic                  last_q;
	bpm_pkg::quad_sample_t word_q;

	assign accept = sample_valid & ~busy;  // offered while busy is dropped

	// short events still need one signal sample after the baseline
	assign len_eff = (evt_len <= BL_LEN) ? BL_LEN + 16'd1 : evt_len;

	assign in_bl   = smp_cnt < BL_LEN;
	assign is_last = ~in_bl & (smp_cnt == len_q - 16'd1);  // never true in baseline

	////////////////////////////////////////////////////////////////////////////
	// sample counter and busy flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			smp_cnt <= '0;
			len_q   <= BL_LEN + 16'd1;
			busy    <= 1'b0;
		end else begin
			if (accept) begin
				if (smp_cnt == '0)
					len_q <= len_eff;  // length fixed at first sample
				smp_cnt <= is_last ? '0 : smp_cnt + 16'd1;
			end
			if (accept && is_last)
				busy <= 1'b1;  // hold off input while packing
			else if (pkt_done)
				busy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// lane strobes, one cycle behind acceptance
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			bl_q   <= 1'b0;
			sig_q  <= 1'b0;
			last_q <= 1'b0;
		end else begin
			bl_q   <= accept & in_bl;
			sig_q  <= accept & ~in_bl;
			last_q <= accept & is_last;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			word_q <= sample_word;  // payload only
	end

	// split the word into four lanes sharing the same tags
	for (genvar g = 0; g < bpm_pkg::NUM_CH; g++) begin : g_lane
		assign lanes[g].sample    = word_q[g];
		assign lanes[g].bl_valid  = bl_q;
		assign lanes[g].sig_valid = sig_q;
		assign lanes[g].last      = last_q;
	end

endmodule

// ==== design/lane_if.sv ====
// one channel's sample stream, framer -> channel processor
interface lane_if;

	bpm_pkg::sample_t sample;     // raw adc value
	logic             bl_valid;   // sample is in baseline window
	logic             sig_valid;  // sample is in signal window
	logic             last;       // final signal sample of event

	modport framer (
		output sample, bl_valid, sig_valid, last
	);

	modport chan (
		input sample, bl_valid, sig_valid, last
	);

endinterface

// ==== design/packet_builder.sv ====
module packet_builder (
	input  logic        clk,
	input  logic        RST_EVENT_NO,
	result_if.packer    res [bpm_pkg::NUM_CH],
	output logic        pkt_valid,
	output logic [31:0] pkt_word,
	output logic        pkt_done   // with the last word
);

	localparam int IDX_W = $clog2(bpm_pkg::PKT_LEN);

	logic [IDX_W-1:0]    idx;       // word to emit next
	logic                active;    // packet in progress
	logic                emit;
	logic [15:0]         evt_cnt;   // packets sent since reset
	logic [15:0]         status;
	bpm_pkg::pkt_word_u  word_nxt;
	logic [bpm_pkg::NUM_CH-1:0] ovf;
	bpm_pkg::sample_t    peak   [bpm_pkg::NUM_CH];
	bpm_pkg::energy_t    energy [bpm_pkg::NUM_CH];

	// pull results out of the interface array
	for (genvar g = 0; g < bpm_pkg::NUM_CH; g++) begin : g_res
		assign peak[g]   = res[g].peak;
		assign energy[g] = res[g].energy;
		assign ovf[g]    = res[g].overflow;
	end

	assign status = {ovf[0], ovf[1], ovf[2], ovf[3], 12'd0};  // A in bit 15

	// all channels finish on the same edge, channel 0 speaks for them
	assign emit = res[0].done | active;

	////////////////////////////////////////////////////////////////////////////
	// word mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		word_nxt.full = '0;
		case (idx)
			0: word_nxt.full = bpm_pkg::PKT_ID;
			1: begin
				word_nxt.half.hi = status;
				word_nxt.half.lo = evt_cnt;
			end
			2: begin
				word_nxt.half.hi = peak[0];
				word_nxt.half.lo = peak[1];
			end
			3: begin
				word_nxt.half.hi = peak[2];
				word_nxt.half.lo = peak[3];
			end
			default: word_nxt.full = energy[idx[1:0]];  // words 4..7, A..D
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// sequencer and event counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			idx       <= '0;
			active    <= 1'b0;
			pkt_valid <= 1'b0;
			pkt_done  <= 1'b0;
			evt_cnt   <= '0;
		end else begin
			pkt_valid <= emit;
			pkt_done  <= 1'b0;
			if (emit) begin
				if (idx == IDX_W'(bpm_pkg::PKT_LEN - 1)) begin
					idx      <= '0;
					active   <= 1'b0;
					pkt_done <= 1'b1;
				end else begin
					idx    <= idx + 1'b1;
					active <= 1'b1;
				end
			end
			if (pkt_done)
				evt_cnt <= evt_cnt + 16'd1;  // wraps at 16 bits
		end
	end

	always_ff @(posedge clk) begin
		if (emit)
			pkt_word <= word_nxt.full;
	end

endmodule

// ==== design/result_if.sv ====
// per-channel event results, channel processor -> packet builder
interface result_if;

	bpm_pkg::sample_t peak;      // max corrected value
	bpm_pkg::energy_t energy;    // saturating sum of squares
	logic             overflow;  // full scale seen in signal window
	logic             done;      // one-cycle pulse, results valid

	modport chan (
		output peak, energy, overflow, done
	);

	modport packer (
		input peak, energy, overflow, done
	);

endinterface

// ==== run.sh ====
#!/bin/sh
# build and run the bpm front end testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_bpm_frontend -o sim_bpm
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_bpm 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tests/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// random source, 32-bit fibonacci lfsr, taps 32 22 2 1
////////////////////////////////////////////////////////////////////////////

logic [31:0] lfsr_state = 32'h7e35_e722;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit, up to 64 bits
function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[62:0], lfsr_state[0]};
	end
	return v;
endfunction

////////////////////////////////////////////////////////////////////////////
// expected packet, word k in bits k*32 +: 32
////////////////////////////////////////////////////////////////////////////

function automatic logic [255:0] ref_packet(input int len, input logic [15:0] cnt);
	logic [255:0] p;
	logic [31:0]  sum;
	logic [15:0]  base;
	logic [15:0]  s;
	logic [15:0]  corr;
	logic [15:0]  peak;
	logic [63:0]  en;     // wide, clipped at the end
	logic [15:0]  status;
	p       = '0;
	status  = '0;
	p[31:0] = 32'h4142504d;  // id word
	for (int c = 0; c < 4; c++) begin
		sum = '0;
		for (int k = 0; k < BL_LEN; k++)
			sum = sum + 32'(evt_buf[k][c*16 +: 16]);
		base = 16'(sum >> BL_LOG2);  // window average
		peak = '0;
		en   = '0;
		for (int k = BL_LEN; k < len; k++) begin
			s    = evt_buf[k][c*16 +: 16];
			corr = (s > base) ? s - base : 16'd0;  // below baseline adds nothing
			if (corr > peak)
				peak = corr;
			en = en + 64'(corr) * 64'(corr);
			if (s == 16'hffff)
				status[15 - c] = 1'b1;  // a in bit 15
		end
		if (en > 64'hffff_ffff)
			en = 64'hffff_ffff;  // sums only grow, so clipping once is enough
		// a|b in word 2, c|d in word 3
		p[(2 + c / 2) * 32 + ((c % 2 == 1) ? 0 : 16) +: 16] = peak;
		p[(4 + c) * 32 +: 32] = en[31:0];
	end
	p[63:32] = {status, cnt};
	return p;
endfunction

////////////////////////////////////////////////////////////////////////////
// failure handling
////////////////////////////////////////////////////////////////////////////

task automatic abort_run(input string why);
	$display("%s", why);
	$display("TESTBENCH FAILED");
	$fatal(1, "run stopped at first error");
endtask

task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act)
		abort_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
endtask

`endif

// ==== tests/tb_bpm_frontend.sv ====
module tb_bpm_frontend;

	localparam int BL_LOG2     = 3;   // dut default
	localparam int BL_LEN      = 1 << BL_LOG2;
	localparam int N_EVENTS    = 22;  // packets over the whole run
	localparam int MAX_LEN     = 64;  // longest evt_len offered
	localparam int TIMEOUT_CYC = N_EVENTS * (MAX_LEN + 20) + 200;

	logic        clk;
	logic        RST_EVENT_NO;
	logic        sample_valid;
	logic [63:0] sample_word;
	logic [15:0] evt_len;
	logic        busy;
	logic        pkt_valid;
	logic [31:0] pkt_word;

	logic [63:0]  evt_buf [0:255];  // accepted words of the open event
	logic [31:0]  exp_q [$];        // expected packet words, in order
	logic [255:0] pkt_exp;
	logic [31:0]  got_exp;
	logic [15:0]  model_cnt;
	int           cur_n;
	int           cur_len;
	int           events_seen;
	int           dropped;
	int           busy_left;        // edges still expected to see busy high
	int           word_idx;         // position inside the current packet
	string        test_name;

	`include "tb_model.svh"

	bpm_frontend_top #(
		.BL_LOG2 (BL_LOG2)
	) i_dut (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.sample_valid (sample_valid),
		.sample_word  (sample_word),
		.evt_len      (evt_len),
		.busy         (busy),
		.pkt_valid    (pkt_valid),
		.pkt_word     (pkt_word)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		abort_run($sformatf("watchdog expired, run not done after %0d cycles", TIMEOUT_CYC));
	end

	////////////////////////////////////////////////////////////////////////////
	// event recorder, same acceptance rule as the framer
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (RST_EVENT_NO) begin
			cur_n     = 0;
			model_cnt = '0;
			busy_left = 0;
		end else begin
			// busy from the edge after the last sample through the last packet word
			compare_word($sformatf("%s busy flag", test_name), 32'(busy_left > 0), 32'(busy));
			if (busy_left > 0)
				busy_left--;
			if (sample_valid && busy) begin
				dropped++;
			end else if (sample_valid) begin
				if (cur_n == 0)
					cur_len = (evt_len <= BL_LEN) ? BL_LEN + 1 : int'(evt_len);  // min length
				evt_buf[cur_n] = sample_word;
				cur_n++;
				if (cur_n == cur_len) begin
					pkt_exp = ref_packet(cur_len, model_cnt);
					for (int k = 0; k < 8; k++)
						exp_q.push_back(pkt_exp[k*32 +: 32]);
					model_cnt++;
					events_seen++;
					busy_left = 10;  // edges N+1 to N+10
					cur_n = 0;
				end
			end
		end
	end

	// packet checker
	always @(posedge clk) begin
		if (pkt_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("packet word arrived with no finished event behind it");
			end else begin
				got_exp = exp_q.pop_front();
				compare_word($sformatf("%s word %0d", test_name, word_idx), got_exp, pkt_word);
				word_idx = (word_idx + 1) % 8;
			end
		end else if (word_idx != 0) begin
			abort_run($sformatf("packet broke off after %0d words", word_idx));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus, all on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic send_word(input logic [63:0] w, input logic [15:0] len_cfg);
		@(negedge clk);
		sample_valid = 1'b1;
		sample_word  = w;
		evt_len      = len_cfg;
	endtask

	task automatic finish_event();
		int n;
		n = 0;
		@(negedge clk);
		sample_valid = 1'b0;
		while ((exp_q.size() != 0 || busy) && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0 || busy)
			abort_run("expected packet did not come out after the event");
	endtask

	task automatic apply_reset();
		@(negedge clk);
		RST_EVENT_NO = 1'b1;
		sample_valid = 1'b0;
		repeat (5) @(negedge clk);
		RST_EVENT_NO = 1'b0;
	endtask

	// big: low baseline, signal with the top bit set, so energy saturates
	task automatic random_event(input logic [15:0] len_cfg, input logic big);
		int          n;
		logic [63:0] w;
		n = (len_cfg <= BL_LEN) ? BL_LEN + 1 : int'(len_cfg);
		for (int k = 0; k < n; k++) begin
			w = rand_bits(64);
			if (big)
				w = (k < BL_LEN) ? w & {4{16'h00ff}} : w | {4{16'h8000}};
			send_word(w, len_cfg);
		end
		finish_event();
	endtask

	initial begin
		logic [63:0] w;
		int          h;
		int          target;
		RST_EVENT_NO = 1'b1;
		sample_valid = 1'b0;
		sample_word  = '0;
		evt_len      = '0;
		test_name    = "reset";
		apply_reset();

		// flat baseline, triangular pulse, height grows with channel
		test_name = "baseline";
		for (int k = 0; k < 20; k++) begin
			h = (k < BL_LEN) ? 0 : (k <= 13) ? 40 * (k - 7) : 40 * (20 - k);
			for (int c = 0; c < 4; c++)
				w[c*16 +: 16] = 16'(100 + 5000 * c + h * (c + 1));
			send_word(w, 16'd20);
		end
		finish_event();

		test_name = "clamp";  // odd samples dip under the baseline
		for (int k = 0; k < 24; k++) begin
			for (int c = 0; c < 4; c++)
				w[c*16 +: 16] = (k < BL_LEN) ? 16'd5000 :
					(k % 2 == 1) ? 16'(4000 + 50 * c) : 16'(5000 + k * (c + 1));
			send_word(w, 16'd24);
		end
		finish_event();
		test_name = "saturate";
		repeat (3) random_event(16'd40, 1'b1);

		test_name = "overflow";
		for (int k = 0; k < 16; k++) begin
			w = rand_bits(64) & {4{16'h0fff}};
			if (k == 2)
				w[63:48] = 16'hffff;  // d, inside baseline
			if (k == 11)
				w[31:16] = 16'hffff;  // b, inside signal
			send_word(w, 16'd16);
		end
		finish_event();

		test_name = "numbering";
		apply_reset();
		random_event(16'd12, 1'b0);
		random_event(16'd3, 1'b0);  // under the minimum
		random_event(16'd30, 1'b0);
		test_name = "count restart";
		apply_reset();
		random_event(16'd10, 1'b0);

		// valid held high through packing, random lengths 0..63
		test_name = "busy drop";
		target    = events_seen + 12;
		while (events_seen < target)
			send_word(rand_bits(64), 16'(rand_bits(6)));
		finish_event();

		if (dropped == 0) begin
			abort_run("no sample was ever offered while busy was high");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule
